/* design/fd_pkg.sv */
`default_nettype none

package fd_pkg;

    // ==========================================================
    // widths
    // ==========================================================
    localparam int ID_W      = 8;
    localparam int WORD_W    = 64;
    localparam int HALF_W    = WORD_W / 2;
    localparam int STOCK_W   = 8;
    localparam int CTM_SER_W = 4;
    localparam int ORD_SER_W = 6;

    // ==========================================================
    // enums
    // ==========================================================
    typedef enum logic [1:0] {no_action, take, deliver, order} action_e;

    typedef enum logic [2:0] {
        no_err,
        no_food,
        d_man_busy,
        no_customers,
        res_busy
    } err_e;

    typedef enum logic [1:0] {food_none, food1, food2, food3} food_e;

    // normal is nonzero so a filled slot never reads as empty
    typedef enum logic [1:0] {normal = 2'd1, vip = 2'd3} status_e;

    typedef enum logic [2:0] {
        idle,
        load_d,
        load_r,
        calc,
        store_d,
        store_r,
        done
    } fd_state_e;

    // ==========================================================
    // records and buses
    // ==========================================================
    // all zero means an empty slot
    typedef struct packed {
        status_e              status;
        logic [ID_W-1:0]      res_id;
        food_e                food;
        logic [CTM_SER_W-1:0] servings;
    } ctm_info_t;

    // slot1 is the front customer, low half of a memory word
    typedef struct packed {
        ctm_info_t slot1;
        ctm_info_t slot2;
    } d_man_info_t;

    // high half of a memory word
    typedef struct packed {
        logic [STOCK_W-1:0] limit;
        logic [STOCK_W-1:0] ser_food1;
        logic [STOCK_W-1:0] ser_food2;
        logic [STOCK_W-1:0] ser_food3;
    } res_info_t;

    // take uses ctm, order uses res_id, food and servings
    typedef struct packed {
        action_e              action;
        logic [ID_W-1:0]      d_id;
        logic [ID_W-1:0]      res_id;
        ctm_info_t            ctm;
        food_e                food;
        logic [ORD_SER_W-1:0] servings;
    } cmd_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ID_W-1:0]   adr;
        logic [WORD_W-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_s2m_t;

    typedef struct packed {
        err_e              err;
        logic              complete;
        logic [WORD_W-1:0] info;
    } result_t;

endpackage

`default_nettype wire

/* design/fd_rules.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_rules import fd_pkg::*; (
    input  cmd_t        cur_cmd,
    input  d_man_info_t dman,
    input  res_info_t   res,
    output d_man_info_t new_dman,
    output res_info_t   new_res,
    output err_e        err
);

    // stock of one food, zero for food_none
    function automatic logic [STOCK_W-1:0] get_stock(res_info_t r, food_e f);
        case (f)
            food1:   return r.ser_food1;
            food2:   return r.ser_food2;
            food3:   return r.ser_food3;
            default: return '0;
        endcase
    endfunction

    function automatic res_info_t set_stock(res_info_t r, food_e f,
                                            logic [STOCK_W-1:0] v);
        res_info_t o;
        o = r;
        case (f)
            food1:   o.ser_food1 = v;
            food2:   o.ser_food2 = v;
            food3:   o.ser_food3 = v;
            default: o = r;
        endcase
        return o;
    endfunction

    ctm_info_t          ctm;
    logic [STOCK_W-1:0] take_stock;
    logic [STOCK_W-1:0] take_ser;
    logic [STOCK_W-1:0] ord_stock;
    logic [STOCK_W-1:0] ord_ser;
    logic [STOCK_W+1:0] ord_total;
    logic               slot1_full;
    logic               slot2_full;

    assign ctm        = cur_cmd.ctm;
    assign take_stock = get_stock(res, ctm.food);
    assign take_ser   = {{(STOCK_W-CTM_SER_W){1'b0}}, ctm.servings};
    assign ord_stock  = get_stock(res, cur_cmd.food);
    assign ord_ser    = {{(STOCK_W-ORD_SER_W){1'b0}}, cur_cmd.servings};
    assign slot1_full = (dman.slot1 != '0);
    assign slot2_full = (dman.slot2 != '0);

    // all stock plus the new servings, against the limit
    assign ord_total = {2'b00, res.ser_food1} + {2'b00, res.ser_food2} +
                       {2'b00, res.ser_food3} + {2'b00, ord_ser};

    // ==========================================================
    // action rules
    // ==========================================================
    always_comb
    begin
        new_dman = dman;
        new_res  = res;
        err      = no_err;
        case (cur_cmd.action)
            take:
            begin
                if (slot1_full && slot2_full)
                    err = d_man_busy;
                else if (take_stock < take_ser)
                    err = no_food;
                else
                begin
                    new_res = set_stock(res, ctm.food, take_stock - take_ser);
                    if (!slot1_full)
                        new_dman.slot1 = ctm;
                    // vip overtakes a normal front customer
                    else if (ctm.status == vip && dman.slot1.status != vip)
                    begin
                        new_dman.slot1 = ctm;
                        new_dman.slot2 = dman.slot1;
                    end
                    else
                        new_dman.slot2 = ctm;
                end
            end
            deliver:
            begin
                if (!slot1_full)
                    err = no_customers;
                else
                begin
                    new_dman.slot1 = dman.slot2;
                    new_dman.slot2 = '0;
                end
            end
            order:
            begin
                if (ord_total > {2'b00, res.limit})
                    err = res_busy;
                else
                    new_res = set_stock(res, cur_cmd.food, ord_stock + ord_ser);
            end
            default:
                err = no_err;
        endcase
    end

endmodule

`default_nettype wire

/* design/fd_wb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_wb_master import fd_pkg::*; (
    input  logic              clk,
    input  logic              inf,
    input  logic              xfer_start,
    input  logic              xfer_we,
    input  logic [ID_W-1:0]   xfer_adr,
    input  logic [WORD_W-1:0] wr_data,
    output logic              xfer_done,
    output logic [WORD_W-1:0] rd_data,
    output wb_m2s_t           wb_o,
    input  wb_s2m_t           wb_i
);

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ID_W-1:0]   adr;
    logic [WORD_W-1:0] dat;
    logic              ack_seen;

    assign ack_seen = cyc && wb_i.ack;

    // classic cycle, held until ack
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            cyc       <= 1'b0;
            stb       <= 1'b0;
            we        <= 1'b0;
            xfer_done <= 1'b0;
        end
        else
        begin
            xfer_done <= ack_seen;
            if (ack_seen)
            begin
                cyc <= 1'b0;
                stb <= 1'b0;
                we  <= 1'b0;
            end
            else if (xfer_start && !cyc)
            begin
                cyc <= 1'b1;
                stb <= 1'b1;
                we  <= xfer_we;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer_start && !cyc)
        begin
            adr <= xfer_adr;
            dat <= wr_data;
        end
        if (ack_seen)
            rd_data <= wb_i.dat;
    end

    assign wb_o = '{cyc: cyc, stb: stb, we: we, adr: adr, dat: dat};

endmodule

`default_nettype wire

/* design/fd_record_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_record_buf import fd_pkg::*; (
    input  logic              clk,
    input  logic              inf,
    input  logic [WORD_W-1:0] rd_data,
    input  logic              load_d,
    input  logic              load_r,
    input  logic              calc_en,
    input  logic              same_word,
    input  d_man_info_t       new_dman,
    input  res_info_t         new_res,
    input  err_e              err,
    input  action_e           action,
    output d_man_info_t       dman,
    output res_info_t         res,
    output logic [WORD_W-1:0] wr_d_word,
    output logic [WORD_W-1:0] wr_r_word,
    output result_t           result_info
);

    logic [WORD_W-1:0] d_word;
    logic [WORD_W-1:0] r_word;
    d_man_info_t       dman_q;
    res_info_t         res_q;
    err_e              err_q;
    logic [WORD_W-1:0] info_word;

    // words as read, and records after calc
    always_ff @(posedge clk)
    begin
        if (load_d)
            d_word <= rd_data;
        // shared word gives the restaurant half on the first read
        if (load_r || (load_d && same_word))
            r_word <= rd_data;
        if (calc_en)
        begin
            dman_q <= new_dman;
            res_q  <= new_res;
        end
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            err_q <= no_err;
        else if (calc_en)
            err_q <= err;
    end

    assign dman = d_word[HALF_W-1:0];
    assign res  = r_word[WORD_W-1:HALF_W];

    // other half of each word comes back unchanged
    assign wr_d_word = same_word ? {res_q, dman_q} : {d_word[WORD_W-1:HALF_W], dman_q};
    assign wr_r_word = {res_q, r_word[HALF_W-1:0]};

    always_comb
    begin
        if (err_q != no_err)
            info_word = '0;
        else
        begin
            case (action)
                take:    info_word = {dman_q, res_q};
                deliver: info_word = {dman_q, {HALF_W{1'b0}}};
                order:   info_word = {{HALF_W{1'b0}}, res_q};
                default: info_word = '0;
            endcase
        end
    end

    assign result_info = '{err: err_q, complete: (err_q == no_err), info: info_word};

endmodule

`default_nettype wire

/* design/fd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_ctrl import fd_pkg::*; (
    input  logic            clk,
    input  logic            inf,
    input  logic            cmd_valid,
    input  cmd_t            cmd,
    output logic            busy,
    output cmd_t            cur_cmd,
    output logic            same_word,
    input  err_e            err,
    output logic            xfer_start,
    output logic            xfer_we,
    output logic [ID_W-1:0] xfer_adr,
    output logic            xfer_sel,
    input  logic            xfer_done,
    output logic            load_d,
    output logic            load_r,
    output logic            calc_en,
    output logic            out_valid
);

    fd_state_e       state;
    fd_state_e       next_state;
    logic            accept;
    logic            xfer_state;
    logic            issued;
    logic [ID_W-1:0] res_adr;

    assign busy   = (state != idle);
    assign accept = cmd_valid && !busy;

    // take with d_id == res_id touches one word only
    assign same_word = (cur_cmd.action == take) && (cur_cmd.d_id == cur_cmd.ctm.res_id);
    assign res_adr   = (cur_cmd.action == take) ? cur_cmd.ctm.res_id : cur_cmd.res_id;

    // ==========================================================
    // state and command registers
    // ==========================================================
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state   <= idle;
            cur_cmd <= '0;
        end
        else
        begin
            state <= next_state;
            if (accept)
                cur_cmd <= cmd;
        end
    end

    // load_d and load_r are also strobe port names, so package scope here
    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (accept && cmd.action == order)
                    next_state = fd_pkg::load_r;
                else if (accept && cmd.action != no_action)
                    next_state = fd_pkg::load_d;
            end
            fd_pkg::load_d:
            begin
                if (xfer_done)
                    next_state = (cur_cmd.action == deliver || same_word) ?
                                 calc : fd_pkg::load_r;
            end
            fd_pkg::load_r:
            begin
                if (xfer_done)
                    next_state = calc;
            end
            calc:
            begin
                if (err != no_err)
                    next_state = done;
                else if (cur_cmd.action == order)
                    next_state = store_r;
                else
                    next_state = store_d;
            end
            store_d:
            begin
                if (xfer_done)
                    next_state = (cur_cmd.action == take && !same_word) ? store_r : done;
            end
            store_r:
            begin
                if (xfer_done)
                    next_state = done;
            end
            default:
                next_state = idle;
        endcase
    end

    // ==========================================================
    // transfer requests
    // ==========================================================
    assign xfer_state = state inside {fd_pkg::load_d, fd_pkg::load_r, store_d, store_r};
    assign xfer_we    = state inside {store_d, store_r};
    assign xfer_sel   = state inside {fd_pkg::load_r, store_r};
    assign xfer_adr   = xfer_sel ? res_adr : cur_cmd.d_id;

    // one start pulse per transfer state, a cycle after entry
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            xfer_start <= 1'b0;
            issued     <= 1'b0;
            out_valid  <= 1'b0;
        end
        else
        begin
            xfer_start <= 1'b0;
            out_valid  <= (state == done);
            if (xfer_done)
                issued <= 1'b0;
            else if (xfer_state && !issued)
            begin
                xfer_start <= 1'b1;
                issued     <= 1'b1;
            end
        end
    end

    assign load_d  = (state == fd_pkg::load_d) && xfer_done;
    assign load_r  = (state == fd_pkg::load_r) && xfer_done;
    assign calc_en = (state == calc);

endmodule

`default_nettype wire

/* design/fd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_top import fd_pkg::*; (
    input  logic    clk,
    input  logic    inf,
    input  logic    cmd_valid,
    input  cmd_t    cmd,
    output logic    busy,
    output logic    out_valid,
    output result_t result,
    output wb_m2s_t wb_o,
    input  wb_s2m_t wb_i
);

    cmd_t              cur_cmd;
    logic              same_word;
    err_e              err;
    logic              xfer_start;
    logic              xfer_we;
    logic [ID_W-1:0]   xfer_adr;
    logic              xfer_sel;
    logic              xfer_done;
    logic              load_d;
    logic              load_r;
    logic              calc_en;
    logic [WORD_W-1:0] rd_data;
    logic [WORD_W-1:0] wr_d_word;
    logic [WORD_W-1:0] wr_r_word;
    d_man_info_t       dman;
    d_man_info_t       new_dman;
    res_info_t         res;
    res_info_t         new_res;

    fd_ctrl u_ctrl (
        .clk        (clk),
        .inf        (inf),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .cur_cmd    (cur_cmd),
        .same_word  (same_word),
        .err        (err),
        .xfer_start (xfer_start),
        .xfer_we    (xfer_we),
        .xfer_adr   (xfer_adr),
        .xfer_sel   (xfer_sel),
        .xfer_done  (xfer_done),
        .load_d     (load_d),
        .load_r     (load_r),
        .calc_en    (calc_en),
        .out_valid  (out_valid)
    );

    fd_record_buf u_buf (
        .clk         (clk),
        .inf         (inf),
        .rd_data     (rd_data),
        .load_d      (load_d),
        .load_r      (load_r),
        .calc_en     (calc_en),
        .same_word   (same_word),
        .new_dman    (new_dman),
        .new_res     (new_res),
        .err         (err),
        .action      (cur_cmd.action),
        .dman        (dman),
        .res         (res),
        .wr_d_word   (wr_d_word),
        .wr_r_word   (wr_r_word),
        .result_info (result)
    );

    fd_rules u_rules (
        .cur_cmd  (cur_cmd),
        .dman     (dman),
        .res      (res),
        .new_dman (new_dman),
        .new_res  (new_res),
        .err      (err)
    );

    // restaurant word on xfer_sel
    fd_wb_master u_wb (
        .clk        (clk),
        .inf        (inf),
        .xfer_start (xfer_start),
        .xfer_we    (xfer_we),
        .xfer_adr   (xfer_adr),
        .wr_data    (xfer_sel ? wr_r_word : wr_d_word),
        .xfer_done  (xfer_done),
        .rd_data    (rd_data),
        .wb_o       (wb_o),
        .wb_i       (wb_i)
    );

endmodule

`default_nettype wire

/* dv/fd_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_mem_model import fd_pkg::*; (
    input  logic    clk,
    input  logic    inf,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    localparam logic [31:0] LFSR_SEED = 32'h79ec_94e2;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [WORD_W-1:0] mem [0:(1 << ID_W)-1];
    logic              ack;
    logic              pending;
    logic [1:0]        wait_cnt;
    logic [WORD_W-1:0] rd_dat;
    logic [31:0]       lfsr;
    logic [31:0]       lfsr_1;
    logic [31:0]       lfsr_2;
    logic              respond;

    // galois form, shifts right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        else
            return s >> 1;
    endfunction

    // two bits per delay, one step per bit
    assign lfsr_1  = lfsr_next(lfsr);
    assign lfsr_2  = lfsr_next(lfsr_1);
    assign respond = wb_i.cyc && wb_i.stb && pending && !ack && (wait_cnt == 2'd0);

    // ==========================================================
    // ack timing, 1 to 4 wait cycles per transfer
    // ==========================================================
    always @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            ack      <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            lfsr     <= LFSR_SEED;
        end
        else if (ack)
        begin
            ack     <= 1'b0;
            pending <= 1'b0;
        end
        else if (wb_i.cyc && wb_i.stb)
        begin
            if (!pending)
            begin
                pending  <= 1'b1;
                wait_cnt <= {lfsr[0], lfsr_1[0]};
                lfsr     <= lfsr_2;
            end
            else if (wait_cnt == 2'd0)
                ack <= 1'b1;
            else
                wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk)
    begin
        if (respond)
        begin
            if (wb_i.we)
                mem[wb_i.adr] = wb_i.dat;
            else
                rd_dat <= mem[wb_i.adr];
        end
    end

    assign wb_o = '{ack: ack, dat: rd_dat};

    // ==========================================================
    // preload and peek
    // ==========================================================
    task clear_all();
        for (int a = 0; a < (1 << ID_W); a++)
            mem[a] = '0;
    endtask

    task write_word(input logic [ID_W-1:0] adr, input logic [WORD_W-1:0] data);
        mem[adr] = data;
    endtask

    function logic [WORD_W-1:0] read_word(input logic [ID_W-1:0] adr);
        return mem[adr];
    endfunction

endmodule

`default_nettype wire

/* dv/fd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fd_tb import fd_pkg::*; ();

    localparam int NUM_TESTS  = 11;
    localparam int WAIT_LIMIT = 200;

    // expected result, plus two memory words to read back afterward
    typedef struct packed {
        err_e              err;
        logic              complete;
        logic [WORD_W-1:0] info;
        logic [ID_W-1:0]   adr_a;
        logic [WORD_W-1:0] word_a;
        logic [ID_W-1:0]   adr_b;
        logic [WORD_W-1:0] word_b;
    } expect_t;

    logic    clk;
    logic    inf;
    logic    cmd_valid;
    cmd_t    cmd;
    logic    busy;
    logic    out_valid;
    result_t result;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;

    string   test_name [NUM_TESTS];
    cmd_t    test_cmd  [NUM_TESTS];
    expect_t test_exp  [NUM_TESTS];
    int      num_entries;
    int      pass_count;
    int      fail_count;
    int      test_errors;
    logic    hung;

    fd_top DUT (
        .clk       (clk),
        .inf       (inf),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .out_valid (out_valid),
        .result    (result),
        .wb_o      (wb_m2s),
        .wb_i      (wb_s2m)
    );

    fd_mem_model u_mem (
        .clk  (clk),
        .inf  (inf),
        .wb_i (wb_m2s),
        .wb_o (wb_s2m)
    );

    initial
    begin
        clk = 1'b0;
    end

    always
    begin
        #2 clk = ~clk;
    end

    // ==========================================================
    // command builders
    // ==========================================================
    function automatic ctm_info_t ctm_of(input status_e s, input logic [ID_W-1:0] rid,
                                         input food_e f, input logic [CTM_SER_W-1:0] n);
        ctm_info_t c;
        c.status   = s;
        c.res_id   = rid;
        c.food     = f;
        c.servings = n;
        return c;
    endfunction

    function automatic cmd_t take_cmd(input logic [ID_W-1:0] d_id, input ctm_info_t c);
        cmd_t t;
        t        = '0;
        t.action = take;
        t.d_id   = d_id;
        t.ctm    = c;
        return t;
    endfunction

    function automatic cmd_t deliver_cmd(input logic [ID_W-1:0] d_id);
        cmd_t t;
        t        = '0;
        t.action = deliver;
        t.d_id   = d_id;
        return t;
    endfunction

    function automatic cmd_t order_cmd(input logic [ID_W-1:0] rid, input food_e f,
                                       input logic [ORD_SER_W-1:0] n);
        cmd_t t;
        t          = '0;
        t.action   = order;
        t.res_id   = rid;
        t.food     = f;
        t.servings = n;
        return t;
    endfunction

    task automatic add_test(input string name, input cmd_t c, input err_e err,
                            input logic cmpl, input logic [WORD_W-1:0] info,
                            input logic [ID_W-1:0] adr_a, input logic [WORD_W-1:0] word_a,
                            input logic [ID_W-1:0] adr_b, input logic [WORD_W-1:0] word_b);
        test_name[num_entries]         = name;
        test_cmd[num_entries]          = c;
        test_exp[num_entries].err      = err;
        test_exp[num_entries].complete = cmpl;
        test_exp[num_entries].info     = info;
        test_exp[num_entries].adr_a    = adr_a;
        test_exp[num_entries].word_a   = word_a;
        test_exp[num_entries].adr_b    = adr_b;
        test_exp[num_entries].word_b   = word_b;
        num_entries++;
    endtask

    // ==========================================================
    // command table, words are {restaurant, delivery man}
    // ==========================================================
    // unused id fields are zero, so a stray store of the other record lands at 00
    task automatic build_table();
        add_test("take_empty", take_cmd(8'h10, ctm_of(normal, 8'h20, food1, 4'd3)),
                 no_err, 1'b1, 64'h4813_0000_6411_0a05,
                 8'h10, 64'haa55_1234_4813_0000, 8'h20, 64'h6411_0a05_1357_2468);
        // vip moves ahead of the normal front customer
        add_test("take_vip_ahead", take_cmd(8'h11, ctm_of(vip, 8'h20, food3, 4'd4)),
                 no_err, 1'b1, 64'hc834_4862_6411_0a01,
                 8'h11, 64'h0f0f_0f0f_c834_4862, 8'h20, 64'h6411_0a01_1357_2468);
        add_test("take_busy", take_cmd(8'h11, ctm_of(normal, 8'h20, food1, 4'd1)),
                 d_man_busy, 1'b0, 64'h0,
                 8'h11, 64'h0f0f_0f0f_c834_4862, 8'h20, 64'h6411_0a01_1357_2468);
        // only one serving of food3 left
        add_test("take_no_food", take_cmd(8'h10, ctm_of(normal, 8'h20, food3, 4'd2)),
                 no_food, 1'b0, 64'h0,
                 8'h10, 64'haa55_1234_4813_0000, 8'h20, 64'h6411_0a01_1357_2468);
        add_test("deliver_shift", deliver_cmd(8'h11),
                 no_err, 1'b1, 64'h4862_0000_0000_0000,
                 8'h11, 64'h0f0f_0f0f_4862_0000, 8'h00, 64'h0);
        add_test("deliver_empty", deliver_cmd(8'h14),
                 no_customers, 1'b0, 64'h0,
                 8'h14, 64'h5a5a_5a5a_0000_0000, 8'h00, 64'h0);
        // limit 50, stock 30 before
        add_test("order_ok", order_cmd(8'h21, food2, 6'd15),
                 no_err, 1'b1, 64'h0000_0000_320a_190a,
                 8'h21, 64'h320a_190a_2468_ace0, 8'h00, 64'h0);
        add_test("order_over", order_cmd(8'h21, food1, 6'd6),
                 res_busy, 1'b0, 64'h0,
                 8'h21, 64'h320a_190a_2468_ace0, 8'h00, 64'h0);
        add_test("order_at_limit", order_cmd(8'h21, food3, 6'd5),
                 no_err, 1'b1, 64'h0000_0000_320a_190f,
                 8'h21, 64'h320a_190f_2468_ace0, 8'h00, 64'h0);
        // one word holds both records
        add_test("take_shared", take_cmd(8'h30, ctm_of(normal, 8'h30, food2, 4'd5)),
                 no_err, 1'b1, 64'h4c25_0000_3c08_0308,
                 8'h30, 64'h3c08_0308_4c25_0000, 8'h00, 64'h0);
        add_test("take_shared_slot2", take_cmd(8'h30, ctm_of(normal, 8'h30, food1, 4'd8)),
                 no_err, 1'b1, 64'h4c25_4c18_3c00_0308,
                 8'h30, 64'h3c00_0308_4c25_4c18, 8'h00, 64'h0);
    endtask

    task automatic load_memory();
        u_mem.clear_all();
        u_mem.write_word(8'h10, 64'haa55_1234_0000_0000);
        u_mem.write_word(8'h11, 64'h0f0f_0f0f_4862_0000);
        u_mem.write_word(8'h14, 64'h5a5a_5a5a_0000_0000);
        u_mem.write_word(8'h20, 64'h6414_0a05_1357_2468);
        u_mem.write_word(8'h21, 64'h320a_0a0a_2468_ace0);
        u_mem.write_word(8'h30, 64'h3c08_0808_0000_0000);
    endtask

    // ==========================================================
    // checks and reporting
    // ==========================================================
    task automatic report_mismatch(input string name, input string field,
                                   input logic [WORD_W-1:0] expected,
                                   input logic [WORD_W-1:0] actual);
        $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            pass_count++;
            $display("PASS %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, test_errors);
        end
    endtask

    task automatic apply_reset();
        inf = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        inf = 1'b1;
    endtask

    task automatic check_reset();
        test_errors = 0;
        if (busy !== 1'b0)
            report_mismatch("reset_state", "busy", 64'd0, 64'(busy));
        if (out_valid !== 1'b0)
            report_mismatch("reset_state", "out_valid", 64'd0, 64'(out_valid));
        if ({wb_m2s.cyc, wb_m2s.stb, wb_m2s.we} !== 3'b000)
            report_mismatch("reset_state", "cyc_stb_we", 64'd0,
                            64'({wb_m2s.cyc, wb_m2s.stb, wb_m2s.we}));
        if (result.err !== no_err)
            report_mismatch("reset_state", "err", 64'(no_err), 64'(result.err));
        finish_test("reset_state");
    endtask

    task automatic run_test(input int idx);
        int                waited;
        expect_t           e;
        logic [WORD_W-1:0] mem_word;
        e           = test_exp[idx];
        test_errors = 0;
        waited      = 0;
        while (busy && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (busy)
        begin
            $display("%s: engine still busy after %0d cycles", test_name[idx], WAIT_LIMIT);
            test_errors++;
            hung = 1'b1;
            finish_test(test_name[idx]);
            return;
        end
        cmd       = test_cmd[idx];
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        if (!busy)
        begin
            $display("%s: command was not accepted", test_name[idx]);
            test_errors++;
        end
        // wait for the result pulse
        waited = 0;
        while (!out_valid && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid)
        begin
            $display("%s: no result within %0d cycles", test_name[idx], WAIT_LIMIT);
            test_errors++;
            hung = 1'b1;
            finish_test(test_name[idx]);
            return;
        end
        if (result.err !== e.err)
            report_mismatch(test_name[idx], "err", 64'(e.err), 64'(result.err));
        if (result.complete !== e.complete)
            report_mismatch(test_name[idx], "complete", 64'(e.complete), 64'(result.complete));
        if (result.info !== e.info)
            report_mismatch(test_name[idx], "info", e.info, result.info);
        if (busy)
        begin
            $display("%s: busy still high with the result", test_name[idx]);
            test_errors++;
        end
        @(negedge clk);
        if (out_valid)
        begin
            $display("%s: result pulse longer than one cycle", test_name[idx]);
            test_errors++;
        end
        mem_word = u_mem.read_word(e.adr_a);
        if (mem_word !== e.word_a)
            report_mismatch(test_name[idx], $sformatf("mem[%h]", e.adr_a), e.word_a, mem_word);
        mem_word = u_mem.read_word(e.adr_b);
        if (mem_word !== e.word_b)
            report_mismatch(test_name[idx], $sformatf("mem[%h]", e.adr_b), e.word_b, mem_word);
        finish_test(test_name[idx]);
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================
    initial
    begin
        int idx;
        inf         = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        hung        = 1'b0;
        num_entries = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        build_table();
        load_memory();
        apply_reset();
        check_reset();
        idx = 0;
        while (idx < num_entries && !hung)
        begin
            run_test(idx);
            idx++;
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (hung || fail_count != 0)
            $display("ERRORS FOUND");
        else
            $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/fd_pkg.sv
design/fd_rules.sv
design/fd_wb_master.sv
design/fd_record_buf.sv
design/fd_ctrl.sv
design/fd_top.sv
dv/fd_mem_model.sv
dv/fd_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = fd_tb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
